//--- files.f
design/icache_addr_pkg.sv
design/icache_way_pkg.sv
design/icache_way_ram.sv
design/icache_lookup.sv
design/icache_refill.sv
design/icache_top.sv
tb/icache_chk.sv
tb/icache_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module icache_tb -Mdir obj_dir -f files.f &&
./obj_dir/Vicache_tb +verilator+error+limit+100000 | tee /dev/stderr |
    grep -q "^Verification passed$" &&
echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }

//--- tb/icache_tb.sv
// Instruction cache testbench: clock, reset, memory model, directed and random fetches.
`timescale 1ns/100ps

module icache_tb
    import icache_addr_pkg::*;
();

    localparam int WAIT_LIMIT     = 400;
    localparam int RANDOM_FETCHES = 300;

    logic       clk;
    logic       rst;
    half_addr_t fetch_addr;
    logic       stall;
    instr_t     instr;
    logic       mem_valid;
    word_addr_t mem_addr;
    logic       mem_ready;
    instr_t     mem_rdata;

    logic [31:0] rand_state = 32'h9d6f4d01;
    int          err_cnt = 0;

    icache_top i_dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .fetch_addr_i (fetch_addr),
        .stall_o      (stall),
        .instr_o      (instr),
        .mem_valid_o  (mem_valid),
        .mem_addr_o   (mem_addr),
        .mem_ready_i  (mem_ready),
        .mem_rdata_i  (mem_rdata)
    );

    bind icache_top icache_chk i_chk (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fetch_addr_i (fetch_addr_i),
        .stall_i      (stall_o),
        .instr_i      (instr_o),
        .mem_valid_i  (mem_valid_o),
        .mem_addr_i   (mem_addr_o),
        .mem_ready_i  (mem_ready_i),
        .init_busy_i  (init_busy),
        .way0_we_i    (way0_we),
        .way1_we_i    (way1_we)
    );

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Upper half is the address XOR 5a5a, lower half its inverse.
    function automatic instr_t mem_word(word_addr_t w);
        return {w[15:0] ^ 16'h5a5a, ~w[15:0]};
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Answers each request after 0 to 5 idle cycles.
    initial begin : memory_model
        word_addr_t req_addr;
        int         lat;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_valid) begin
                req_addr = mem_addr;
                lat = (next_rand() >> 16) % 6;
                repeat (lat) @(posedge clk);
                @(posedge clk);
                #1;
                mem_ready = 1'b1;
                mem_rdata = mem_word(req_addr);
                @(posedge clk);
                #1;
                mem_ready = 1'b0;
            end
        end
    end

    // Holds the address until the cache stops stalling.
    task automatic fetch(input half_addr_t addr, output logic missed);
        int cycles;
        fetch_addr = addr;
        cycles = 0;
        @(negedge clk);
        missed = mem_valid;
        while (stall && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (stall) begin
            err_cnt++;
            $display("Timeout: fetch of halfword address %h was never accepted", addr);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_fetch(input half_addr_t addr, input logic want_miss);
        logic missed;
        fetch(addr, missed);
        if (missed != want_miss) begin
            err_cnt++;
            $display("[ERROR] %0t: fetch %h miss was %b, expected %b",
                     $time, addr, missed, want_miss);
        end
    endtask

    // Tags A, B, C into one set, then B must still hit and A must miss.
    task automatic run_replacement(input set_idx_t set);
        half_addr_t a;
        half_addr_t b;
        half_addr_t c;
        a = {9'd5, set, 1'b0};
        b = {9'd6, set, 1'b0};
        c = {9'd7, set, 1'b0};
        check_fetch(a, 1'b1);
        check_fetch(b, 1'b1);
        check_fetch(c, 1'b1);
        check_fetch(b, 1'b0);
        check_fetch(a, 1'b1);
    endtask

    // Three tags only, so sets collide often.
    task automatic run_random();
        logic [31:0] r;
        tag_t        rand_tag;
        logic        missed;
        for (int i = 0; i < RANDOM_FETCHES; i++) begin
            r = next_rand();
            rand_tag = tag_t'(r[31:24] % 8'd3);
            fetch({rand_tag, r[23:16], r[8]}, missed);
        end
    endtask

    initial begin : stimulus
        logic missed;
        rst = 1'b1;
        fetch_addr = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // First fetch also waits out the clear.
        fetch({9'd0, 8'h10, 1'b0}, missed);
        check_fetch({9'd0, 8'h10, 1'b0}, 1'b0);
        // Low word cached, next word missing.
        check_fetch({9'd0, 8'h10, 1'b1}, 1'b1);
        check_fetch({9'd0, 8'h10, 1'b1}, 1'b0);
        // Set 255 wraps into the next tag.
        check_fetch({9'd3, 8'hff, 1'b1}, 1'b1);
        check_fetch({9'd3, 8'hff, 1'b1}, 1'b0);
        check_fetch({9'd4, 8'h00, 1'b0}, 1'b0);
        // Last word of the address space wraps to word 0.
        check_fetch({9'h1ff, 8'hff, 1'b1}, 1'b1);
        check_fetch({9'h1ff, 8'hff, 1'b1}, 1'b0);

        run_replacement(8'h80);
        run_random();

        $display("Errors: %0d testbench, %0d assertion", err_cnt, i_dut.i_chk.fail_cnt);
        if (err_cnt == 0 && i_dut.i_chk.fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- tb/icache_chk.sv
// Instruction cache checker: clear phase, hit data, miss requests and way choice.
`timescale 1ns/100ps

module icache_chk
    import icache_addr_pkg::*;
(
    input logic       clk_i,
    input logic       rst_i,
    input half_addr_t fetch_addr_i,
    input logic       stall_i,
    input instr_t     instr_i,
    input logic       mem_valid_i,
    input word_addr_t mem_addr_i,
    input logic       mem_ready_i,
    input logic       init_busy_i,
    input logic       way0_we_i,
    input logic       way1_we_i
);

    int fail_clear = 0;
    int fail_data  = 0;
    int fail_miss  = 0;
    int fail_addr  = 0;
    int fail_hold  = 0;
    int fail_way   = 0;
    int fail_cnt;

    logic [8:0]          init_cnt;
    logic                init_done;
    tag_t                ref_tag0 [NUM_SETS];
    tag_t                ref_tag1 [NUM_SETS];
    logic [NUM_SETS-1:0] ref_v0;
    logic [NUM_SETS-1:0] ref_v1;
    logic [NUM_SETS-1:0] ref_victim;

    word_addr_t lo_w;
    word_addr_t hi_w;
    set_idx_t   lo_set;
    set_idx_t   hi_set;
    set_idx_t   fill_set;
    logic       lo_cached;
    logic       hi_cached;
    logic       exp_miss;
    logic       fill;
    logic       exp_we0;
    logic       exp_we1;
    word_addr_t exp_addr;
    instr_t     lo_word;
    instr_t     hi_word;
    instr_t     exp_instr;

    function automatic instr_t rule_word(word_addr_t w);
        return {w[15:0] ^ 16'h5a5a, ~w[15:0]};
    endfunction

    assign fail_cnt  = fail_clear + fail_data + fail_miss + fail_addr + fail_hold + fail_way;
    assign init_done = (init_cnt == 9'd256);

    always_comb begin
        lo_w      = fetch_addr_i[17:1];
        hi_w      = lo_w + 17'd1;
        lo_set    = lo_w[7:0];
        hi_set    = hi_w[7:0];
        lo_cached = (ref_v0[lo_set] && ref_tag0[lo_set] == lo_w[16:8])
                 || (ref_v1[lo_set] && ref_tag1[lo_set] == lo_w[16:8]);
        hi_cached = (ref_v0[hi_set] && ref_tag0[hi_set] == hi_w[16:8])
                 || (ref_v1[hi_set] && ref_tag1[hi_set] == hi_w[16:8]);
        lo_word   = rule_word(lo_w);
        hi_word   = rule_word(hi_w);
        exp_instr = fetch_addr_i[0] ? {hi_word[15:0], lo_word[31:16]} : lo_word;
        exp_miss  = !lo_cached || (fetch_addr_i[0] && !hi_cached);
        exp_addr  = lo_cached ? hi_w : lo_w;
        fill_set  = mem_addr_i[7:0];
        fill      = init_done && mem_valid_i && mem_ready_i;
        exp_we0   = fill && ref_victim[fill_set];
        exp_we1   = fill && !ref_victim[fill_set];
    end

    // Reference tags per set, victim 0 fills way1 first.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            init_cnt   <= '0;
            ref_v0     <= '0;
            ref_v1     <= '0;
            ref_victim <= '0;
        end else begin
            if (!init_done) begin
                init_cnt <= init_cnt + 9'd1;
            end
            if (fill) begin
                if (ref_victim[fill_set]) begin
                    ref_v0[fill_set]   <= 1'b1;
                    ref_tag0[fill_set] <= mem_addr_i[16:8];
                end else begin
                    ref_v1[fill_set]   <= 1'b1;
                    ref_tag1[fill_set] <= mem_addr_i[16:8];
                end
                ref_victim[fill_set] <= !ref_victim[fill_set];
            end
        end
    end

    clear_phase: assert property (@(posedge clk_i) disable iff (rst_i)
        (init_busy_i == !init_done) && (init_done || (stall_i && !mem_valid_i)))
        else begin
            $error("[ERROR] %0t: clear phase stall or length wrong", $time);
            fail_clear++;
        end

    hit_data: assert property (@(posedge clk_i) disable iff (rst_i)
        init_done && !stall_i |-> instr_i == exp_instr)
        else begin
            $error("[ERROR] %0t: instr %h, expected %h", $time, instr_i, exp_instr);
            fail_data++;
        end

    miss_flag: assert property (@(posedge clk_i) disable iff (rst_i)
        init_done |-> (stall_i == exp_miss) && (mem_valid_i == exp_miss))
        else begin
            $error("[ERROR] %0t: stall or request does not match the cached words", $time);
            fail_miss++;
        end

    miss_addr: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_valid_i |-> mem_addr_i == exp_addr)
        else begin
            $error("[ERROR] %0t: request %h, expected %h", $time, mem_addr_i, exp_addr);
            fail_addr++;
        end

    req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_addr_i))
        else begin
            $error("[ERROR] %0t: request dropped or changed before ready", $time);
            fail_hold++;
        end

    fill_way: assert property (@(posedge clk_i) disable iff (rst_i)
        init_done |-> (way0_we_i == exp_we0) && (way1_we_i == exp_we1))
        else begin
            $error("[ERROR] %0t: fill wrote the wrong way", $time);
            fail_way++;
        end

endmodule

//--- design/icache_top.sv
// Two-way instruction cache between a halfword fetch port and a word memory.
`timescale 1ns/100ps

module icache_top
    import icache_addr_pkg::*, icache_way_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,

    // Core fetch port.
    input  half_addr_t fetch_addr_i,
    output logic       stall_o,
    output instr_t     instr_o,

    // Memory port.
    output logic       mem_valid_o,
    output word_addr_t mem_addr_o,
    input  logic       mem_ready_i,
    input  instr_t     mem_rdata_i
);

    set_idx_t       rd_set_lo;
    set_idx_t       rd_set_hi;
    way_entry_t     way0_lo;
    way_entry_t     way0_hi;
    way_entry_t     way1_lo;
    way_entry_t     way1_hi;

    lookup_status_t status;
    logic           init_busy;

    logic           way0_we;
    logic           way1_we;
    set_idx_t       wr_set;
    way_entry_t     wr_entry;

    icache_lookup i_lookup (
        .fetch_addr_i (fetch_addr_i),
        .init_busy_i  (init_busy),
        .way0_lo_i    (way0_lo),
        .way0_hi_i    (way0_hi),
        .way1_lo_i    (way1_lo),
        .way1_hi_i    (way1_hi),
        .rd_set_lo_o  (rd_set_lo),
        .rd_set_hi_o  (rd_set_hi),
        .status_o     (status),
        .stall_o      (stall_o),
        .mem_valid_o  (mem_valid_o),
        .mem_addr_o   (mem_addr_o),
        .instr_o      (instr_o)
    );

    icache_refill i_refill (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .status_i    (status),
        .mem_valid_i (mem_valid_o),
        .mem_ready_i (mem_ready_i),
        .mem_rdata_i (mem_rdata_i),
        .init_busy_o (init_busy),
        .way0_we_o   (way0_we),
        .way1_we_o   (way1_we),
        .wr_set_o    (wr_set),
        .wr_entry_o  (wr_entry)
    );

    // Both ways share the write set and entry.
    icache_way_ram i_way0 (
        .clk_i         (clk_i),
        .we_i          (way0_we),
        .wr_set_i      (wr_set),
        .wr_entry_i    (wr_entry),
        .rd_set_lo_i   (rd_set_lo),
        .rd_set_hi_i   (rd_set_hi),
        .rd_entry_lo_o (way0_lo),
        .rd_entry_hi_o (way0_hi)
    );

    icache_way_ram i_way1 (
        .clk_i         (clk_i),
        .we_i          (way1_we),
        .wr_set_i      (wr_set),
        .wr_entry_i    (wr_entry),
        .rd_set_lo_i   (rd_set_lo),
        .rd_set_hi_i   (rd_set_hi),
        .rd_entry_lo_o (way1_lo),
        .rd_entry_hi_o (way1_hi)
    );

endmodule

//--- design/icache_refill.sv
// Instruction cache refill with initial clear, round-robin victim per set and way writes.
`timescale 1ns/100ps

module icache_refill
    import icache_addr_pkg::*, icache_way_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_i,

    input  lookup_status_t status_i,

    input  logic           mem_valid_i,
    input  logic           mem_ready_i,
    input  instr_t         mem_rdata_i,

    output logic           init_busy_o,

    output logic           way0_we_o,
    output logic           way1_we_o,
    output set_idx_t       wr_set_o,
    output way_entry_t     wr_entry_o
);

    // Counter value at which every set has been cleared.
    localparam logic [SET_W:0] CLR_DONE = (SET_W + 1)'(NUM_SETS);

    logic [SET_W:0]    clr_cnt_q;
    logic [NUM_SETS-1:0] victim_q;

    logic       init_busy;
    logic       fill;
    set_idx_t   fill_set;
    logic       fill_victim;
    way_entry_t fill_entry;

    assign init_busy = (clr_cnt_q != CLR_DONE);

    // A fill completes on the handshake cycle.
    assign fill        = !init_busy && mem_valid_i && mem_ready_i;
    assign fill_set    = set_of(status_i.fill_addr);
    assign fill_victim = victim_q[fill_set];

    assign fill_entry.valid = 1'b1;
    assign fill_entry.tag   = tag_of(status_i.fill_addr);
    assign fill_entry.data  = mem_rdata_i;

    // Victim bit 0 picks way1 and 1 picks way0.
    assign way0_we_o = init_busy | (fill & fill_victim);
    assign way1_we_o = init_busy | (fill & !fill_victim);

    // The clear writes an all-zero entry, which is invalid.
    assign wr_set_o   = init_busy ? clr_cnt_q[SET_W-1:0] : fill_set;
    assign wr_entry_o = init_busy ? '0 : fill_entry;

    assign init_busy_o = init_busy;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            clr_cnt_q <= '0;
            victim_q  <= '0;
        end else begin
            if (init_busy) begin
                clr_cnt_q <= clr_cnt_q + (SET_W + 1)'(1);
            end
            // Alternate the ways of this set.
            if (fill) begin
                victim_q[fill_set] <= !fill_victim;
            end
        end
    end

endmodule

//--- design/icache_lookup.sv
// Instruction cache lookup: tag compare, instruction assembly, stall and miss address.
`timescale 1ns/100ps

module icache_lookup
    import icache_addr_pkg::*, icache_way_pkg::*;
(
    input  half_addr_t     fetch_addr_i,
    input  logic           init_busy_i,

    input  way_entry_t     way0_lo_i,
    input  way_entry_t     way0_hi_i,
    input  way_entry_t     way1_lo_i,
    input  way_entry_t     way1_hi_i,
    output set_idx_t       rd_set_lo_o,
    output set_idx_t       rd_set_hi_o,

    output lookup_status_t status_o,

    output logic           stall_o,
    output logic           mem_valid_o,
    output word_addr_t     mem_addr_o,
    output instr_t         instr_o
);

    word_addr_t lo_addr;
    word_addr_t hi_addr;
    logic       unaligned;

    logic       hit_lo_way0;
    logic       hit_lo_way1;
    logic       hit_hi_way0;
    logic       hit_hi_way1;
    logic       lo_hit;
    logic       hi_hit;
    logic       miss;

    instr_t     lo_data;
    instr_t     hi_data;

    assign lo_addr   = word_of(fetch_addr_i);
    // Wraps from set 255 into the next tag.
    assign hi_addr   = lo_addr + WORD_ADDR_W'(1);
    assign unaligned = fetch_addr_i[0];

    assign rd_set_lo_o = set_of(lo_addr);
    assign rd_set_hi_o = set_of(hi_addr);

    assign hit_lo_way0 = entry_hit(way0_lo_i, tag_of(lo_addr));
    assign hit_lo_way1 = entry_hit(way1_lo_i, tag_of(lo_addr));
    assign hit_hi_way0 = entry_hit(way0_hi_i, tag_of(hi_addr));
    assign hit_hi_way1 = entry_hit(way1_hi_i, tag_of(hi_addr));

    assign lo_hit = hit_lo_way0 | hit_lo_way1;
    assign hi_hit = hit_hi_way0 | hit_hi_way1;

    // The next word matters only for an unaligned fetch.
    assign miss = !lo_hit || (unaligned && !hi_hit);

    assign lo_data = hit_lo_way0 ? way0_lo_i.data : way1_lo_i.data;
    assign hi_data = hit_hi_way0 ? way0_hi_i.data : way1_hi_i.data;

    // Upper half of the low word, then lower half of the next word above it.
    assign instr_o = unaligned ? {hi_data[15:0], lo_data[31:16]} : lo_data;

    // Low word first when both are missing.
    assign mem_addr_o = lo_hit ? hi_addr : lo_addr;

    assign stall_o     = miss | init_busy_i;
    assign mem_valid_o = miss & !init_busy_i;

    assign status_o.miss        = miss;
    assign status_o.fill_addr   = mem_addr_o;
    assign status_o.hit_lo_way0 = hit_lo_way0;
    assign status_o.hit_lo_way1 = hit_lo_way1;
    assign status_o.hit_hi_way0 = hit_hi_way0;
    assign status_o.hit_hi_way1 = hit_hi_way1;

endmodule

//--- design/icache_way_ram.sv
// Way memory of 256 entries, one synchronous write and two asynchronous reads.
`timescale 1ns/100ps

module icache_way_ram
    import icache_addr_pkg::*, icache_way_pkg::*;
(
    input  logic       clk_i,

    input  logic       we_i,
    input  set_idx_t   wr_set_i,
    input  way_entry_t wr_entry_i,

    input  set_idx_t   rd_set_lo_i,
    input  set_idx_t   rd_set_hi_i,
    output way_entry_t rd_entry_lo_o,
    output way_entry_t rd_entry_hi_o
);

    way_entry_t mem [NUM_SETS];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[wr_set_i] <= wr_entry_i;
        end
    end

    // Both words of an unaligned fetch are read in the same cycle.
    assign rd_entry_lo_o = mem[rd_set_lo_i];
    assign rd_entry_hi_o = mem[rd_set_hi_i];

endmodule

//--- design/icache_way_pkg.sv
// Instruction cache way entry and the status passed from lookup to refill.
package icache_way_pkg;

    import icache_addr_pkg::*;

    // One cache line of one word, 42 bits.
    typedef struct packed {
        logic   valid;
        tag_t   tag;
        instr_t data;
    } way_entry_t;

    // Lookup result for the low and the next word of a fetch.
    typedef struct packed {
        logic       miss;
        word_addr_t fill_addr;
        logic       hit_lo_way0;
        logic       hit_lo_way1;
        logic       hit_hi_way0;
        logic       hit_hi_way1;
    } lookup_status_t;

    // Only valid entries take part in the compare.
    function automatic logic entry_hit(way_entry_t entry, tag_t tag);
        return entry.valid && (entry.tag == tag);
    endfunction

endpackage

//--- design/icache_addr_pkg.sv
// Instruction cache address fields: halfword, word, set and tag types.
package icache_addr_pkg;

    // Field widths of the 18-bit halfword fetch address.
    localparam int unsigned HALF_ADDR_W = 18;
    localparam int unsigned WORD_ADDR_W = HALF_ADDR_W - 1;
    localparam int unsigned SET_W       = 8;
    localparam int unsigned TAG_W       = WORD_ADDR_W - SET_W;
    localparam int unsigned INSTR_W     = 32;

    localparam int unsigned NUM_SETS = 2 ** SET_W;

    // Address bits 18:1.
    typedef logic [HALF_ADDR_W-1:0] half_addr_t;
    // Address bits 18:2.
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [SET_W-1:0]       set_idx_t;
    typedef logic [TAG_W-1:0]       tag_t;
    typedef logic [INSTR_W-1:0]     instr_t;

    // Word holding the first halfword of a fetch.
    function automatic word_addr_t word_of(half_addr_t addr);
        return addr[HALF_ADDR_W-1:1];
    endfunction

    function automatic set_idx_t set_of(word_addr_t addr);
        return addr[SET_W-1:0];
    endfunction

    function automatic tag_t tag_of(word_addr_t addr);
        return addr[WORD_ADDR_W-1:SET_W];
    endfunction

endpackage
